//--- source/imuldiv_pkg.sv
/*
  shared types for the multiply/divide unit
  operands are XLEN wide and every result is twice that
*/
package imuldiv_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // operand width
  localparam int XLEN = 32;
  // full result width
  localparam int DLEN = 2 * XLEN;
  // step counter width in the cores
  localparam int CNT_W = $clog2(XLEN);

  // ------------------------------
  // encodings
  // ------------------------------

  // request opcodes
  typedef enum logic [1:0] {
    OP_MUL,
    OP_MULU,
    OP_DIV,
    OP_DIVU
  } imuldiv_op_e;

  // control state shared by both iterative cores
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DONE
  } imuldiv_state_e;

  // which core an item was sent to
  typedef enum logic {
    UNIT_MUL,
    UNIT_DIV
  } imuldiv_unit_e;

  // ------------------------------
  // payloads
  // ------------------------------

  // external request
  typedef struct packed {
    imuldiv_op_e     op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } imuldiv_req_t;

  // operand stage to core, magnitudes plus sign fixup flags
  typedef struct packed {
    logic [XLEN-1:0] mag_a;
    logic [XLEN-1:0] mag_b;
    // negate low half (product or quotient)
    logic            neg_lo;
    // negate high half (product or remainder)
    logic            neg_hi;
    // multiply negates all 64 bits at once
    logic            is_mul;
  } imuldiv_core_req_t;

  // core to result stage, flags ride along untouched
  typedef struct packed {
    logic [DLEN-1:0] raw;
    logic            neg_lo;
    logic            neg_hi;
    logic            is_mul;
  } imuldiv_core_resp_t;

  // external response
  typedef struct packed {
    logic [DLEN-1:0] result;
  } imuldiv_resp_t;

endpackage

//--- source/imuldiv_operand_stage.sv
/*
  one-entry operand register in front of the two cores
  divide by zero uses the normal sign rules, no special casing here
*/
`timescale 1ns/1ns

module imuldiv_operand_stage (
  input  logic                           clk,
  input  logic                           reset,
  // request from outside
  input  logic                           req_val,
  input  imuldiv_pkg::imuldiv_req_t      req_msg,
  output logic                           req_rdy,
  // to the multiply core
  output logic                           mul_req_val,
  output imuldiv_pkg::imuldiv_core_req_t mul_req_msg,
  input  logic                           mul_req_rdy,
  // to the divide core
  output logic                           div_req_val,
  output imuldiv_pkg::imuldiv_core_req_t div_req_msg,
  input  logic                           div_req_rdy,
  // issue order tag to the result stage
  output logic                           issue_val,
  output imuldiv_pkg::imuldiv_unit_e     issue_unit,
  input  logic                           issue_rdy
);
  import imuldiv_pkg::*;

  logic              val_q;
  imuldiv_req_t      req_q;
  logic              is_mul;
  logic              is_signed;
  logic              sign_a;
  logic              sign_b;
  logic [XLEN-1:0]   mag_a;
  logic [XLEN-1:0]   mag_b;
  logic              core_rdy;
  logic              go;
  imuldiv_core_req_t core_msg;

  // ------------------------------
  // request register
  // ------------------------------

  // empty or draining this cycle
  assign req_rdy = !val_q || go;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_q <= 1'b0;
    end else if (req_rdy) begin
      val_q <= req_val;
    end
  end

  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      req_q <= req_msg;
    end
  end

  // ------------------------------
  // magnitudes and sign flags
  // ------------------------------

  assign is_mul    = (req_q.op == OP_MUL) || (req_q.op == OP_MULU);
  assign is_signed = (req_q.op == OP_MUL) || (req_q.op == OP_DIV);

  // unsigned ops never see a sign
  assign sign_a = is_signed && req_q.a[XLEN-1];
  assign sign_b = is_signed && req_q.b[XLEN-1];

  // two's complement magnitude, most negative value maps to itself unsigned
  assign mag_a = sign_a ? (~req_q.a + 1'b1) : req_q.a;
  assign mag_b = sign_b ? (~req_q.b + 1'b1) : req_q.b;

  always_comb begin
    core_msg.mag_a  = mag_a;
    core_msg.mag_b  = mag_b;
    core_msg.is_mul = is_mul;
    // product or quotient sign
    core_msg.neg_lo = sign_a ^ sign_b;
    // remainder follows the dividend
    core_msg.neg_hi = is_mul ? (sign_a ^ sign_b) : sign_a;
  end

  // ------------------------------
  // dispatch
  // ------------------------------

  assign core_rdy = is_mul ? mul_req_rdy : div_req_rdy;

  // needs both the core and a free slot in the order queue
  assign go = val_q && core_rdy && issue_rdy;

  assign mul_req_val = val_q && is_mul && issue_rdy;
  assign div_req_val = val_q && !is_mul && issue_rdy;
  assign mul_req_msg = core_msg;
  assign div_req_msg = core_msg;

  // tag goes out on the dispatch transfer itself
  assign issue_val  = go;
  assign issue_unit = is_mul ? UNIT_MUL : UNIT_DIV;

endmodule

//--- source/imuldiv_mul_iterative.sv
/*
  shift-add multiplier on unsigned magnitudes, fixed 32 steps
  no early exit for small operands, one item at a time
*/
`timescale 1ns/1ns

module imuldiv_mul_iterative (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req_val,
  input  imuldiv_pkg::imuldiv_core_req_t  req_msg,
  output logic                            req_rdy,
  output logic                            resp_val,
  output imuldiv_pkg::imuldiv_core_resp_t resp_msg,
  input  logic                            resp_rdy
);
  import imuldiv_pkg::*;

  imuldiv_state_e   state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [DLEN-1:0]  a_q;
  logic [XLEN-1:0]  b_q;
  logic [DLEN-1:0]  acc_q;
  logic             neg_lo_q;
  logic             neg_hi_q;
  logic             is_mul_q;

  // control outputs
  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;
  logic acc_en;
  logic acc_sel;
  logic cnt_en;
  logic cnt_sel;
  logic flags_en;

  logic             accept;
  logic             cnt_zero;
  logic [DLEN-1:0]  a_next;
  logic [XLEN-1:0]  b_next;
  logic [DLEN-1:0]  acc_next;
  logic [CNT_W-1:0] cnt_next;

  // ------------------------------
  // control
  // ------------------------------

  assign req_rdy  = (state_q == ST_IDLE);
  assign resp_val = (state_q == ST_DONE);
  assign accept   = req_val && req_rdy;
  assign cnt_zero = (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (accept) state_q <= ST_CALC;
        // last step happens with the counter at zero
        ST_CALC: if (cnt_zero) state_q <= ST_DONE;
        ST_DONE: if (resp_rdy) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    a_en     = 1'b0;
    a_sel    = 1'b0;
    b_en     = 1'b0;
    b_sel    = 1'b0;
    acc_en   = 1'b0;
    acc_sel  = 1'b0;
    cnt_en   = 1'b0;
    cnt_sel  = 1'b0;
    flags_en = 1'b0;
    case (state_q)
      ST_IDLE: begin
        // load operands, clear accumulator, preset counter
        a_en     = accept;
        b_en     = accept;
        acc_en   = accept;
        cnt_en   = accept;
        flags_en = accept;
      end
      ST_CALC: begin
        a_en    = 1'b1;
        a_sel   = 1'b1;
        b_en    = 1'b1;
        b_sel   = 1'b1;
        // add only when the current multiplier bit is set
        acc_en  = b_q[0];
        acc_sel = 1'b1;
        cnt_en  = 1'b1;
        cnt_sel = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // ------------------------------
  // datapath
  // ------------------------------

  assign a_next   = a_sel ? (a_q << 1) : {{XLEN{1'b0}}, req_msg.mag_a};
  assign b_next   = b_sel ? (b_q >> 1) : req_msg.mag_b;
  assign acc_next = acc_sel ? (acc_q + a_q) : '0;
  assign cnt_next = cnt_sel ? (cnt_q - 1'b1) : CNT_W'(XLEN - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (cnt_en) begin
      cnt_q <= cnt_next;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) a_q <= a_next;
    if (b_en) b_q <= b_next;
    if (acc_en) acc_q <= acc_next;
    // sign flags pass straight through to the result stage
    if (flags_en) begin
      neg_lo_q <= req_msg.neg_lo;
      neg_hi_q <= req_msg.neg_hi;
      is_mul_q <= req_msg.is_mul;
    end
  end

  assign resp_msg = '{raw: acc_q, neg_lo: neg_lo_q, neg_hi: neg_hi_q, is_mul: is_mul_q};

endmodule

//--- source/imuldiv_div_iterative.sv
/*
  restoring divider on unsigned magnitudes, fixed 32 steps
  raw result is remainder high, quotient low
*/
`timescale 1ns/1ns

module imuldiv_div_iterative (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req_val,
  input  imuldiv_pkg::imuldiv_core_req_t  req_msg,
  output logic                            req_rdy,
  output logic                            resp_val,
  output imuldiv_pkg::imuldiv_core_resp_t resp_msg,
  input  logic                            resp_rdy
);
  import imuldiv_pkg::*;

  imuldiv_state_e   state_q;
  logic [CNT_W-1:0] cnt_q;
  // partial remainder high, dividend bits then quotient bits low
  logic [DLEN-1:0]  rem_q;
  logic [XLEN-1:0]  dvs_q;
  logic             neg_lo_q;
  logic             neg_hi_q;
  logic             is_mul_q;

  // control outputs
  logic rem_en;
  logic rem_sel;
  logic dvs_en;
  logic cnt_en;
  logic cnt_sel;
  logic flags_en;

  logic             accept;
  logic             cnt_zero;
  logic [XLEN:0]    diff;
  logic             fits;
  logic [DLEN-1:0]  step;
  logic [DLEN-1:0]  rem_next;
  logic [CNT_W-1:0] cnt_next;

  // ------------------------------
  // control
  // ------------------------------

  assign req_rdy  = (state_q == ST_IDLE);
  assign resp_val = (state_q == ST_DONE);
  assign accept   = req_val && req_rdy;
  assign cnt_zero = (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (accept) state_q <= ST_CALC;
        ST_CALC: if (cnt_zero) state_q <= ST_DONE;
        // hold the result until the result stage takes it
        ST_DONE: if (resp_rdy) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    rem_en   = 1'b0;
    rem_sel  = 1'b0;
    dvs_en   = 1'b0;
    cnt_en   = 1'b0;
    cnt_sel  = 1'b0;
    flags_en = 1'b0;
    case (state_q)
      ST_IDLE: begin
        rem_en   = accept;
        dvs_en   = accept;
        cnt_en   = accept;
        flags_en = accept;
      end
      ST_CALC: begin
        // one quotient bit per cycle
        rem_en  = 1'b1;
        rem_sel = 1'b1;
        cnt_en  = 1'b1;
        cnt_sel = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // ------------------------------
  // datapath
  // ------------------------------

  // trial subtract on the shifted upper half, 33 bits so the shifted out bit counts
  assign diff = rem_q[DLEN-1:XLEN-1] - {1'b0, dvs_q};
  // no borrow means the divisor fits
  assign fits = !diff[XLEN];

  // restore by keeping the plain shift when it does not fit
  // zero divisor always fits, so quotient is all ones and remainder is the dividend
  assign step = fits ? {diff[XLEN-1:0], rem_q[XLEN-2:0], 1'b1}
                     : {rem_q[DLEN-2:0], 1'b0};

  assign rem_next = rem_sel ? step : {{XLEN{1'b0}}, req_msg.mag_a};
  assign cnt_next = cnt_sel ? (cnt_q - 1'b1) : CNT_W'(XLEN - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (cnt_en) begin
      cnt_q <= cnt_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rem_en) rem_q <= rem_next;
    if (dvs_en) dvs_q <= req_msg.mag_b;
    if (flags_en) begin
      neg_lo_q <= req_msg.neg_lo;
      neg_hi_q <= req_msg.neg_hi;
      is_mul_q <= req_msg.is_mul;
    end
  end

  assign resp_msg = '{raw: rem_q, neg_lo: neg_lo_q, neg_hi: neg_hi_q, is_mul: is_mul_q};

endmodule

//--- source/imuldiv_result_stage.sv
/*
  returns core results in issue order, one-entry response register
  ORDER_DEPTH must be at least the number of cores
*/
`timescale 1ns/1ns

module imuldiv_result_stage #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                            clk,
  input  logic                            reset,
  // issue order tags from the operand stage
  input  logic                            issue_val,
  input  imuldiv_pkg::imuldiv_unit_e      issue_unit,
  output logic                            issue_rdy,
  // multiply core
  input  logic                            mul_resp_val,
  input  imuldiv_pkg::imuldiv_core_resp_t mul_resp_msg,
  output logic                            mul_resp_rdy,
  // divide core
  input  logic                            div_resp_val,
  input  imuldiv_pkg::imuldiv_core_resp_t div_resp_msg,
  output logic                            div_resp_rdy,
  // response to outside
  output logic                            resp_val,
  output imuldiv_pkg::imuldiv_resp_t      resp_msg,
  input  logic                            resp_rdy
);
  import imuldiv_pkg::*;

  localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int OCC_W = $clog2(ORDER_DEPTH + 1);

  imuldiv_unit_e      order_q [ORDER_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [OCC_W-1:0]   occ_q;
  imuldiv_unit_e      head;
  logic               push;
  logic               pop;
  logic               take_rdy;
  imuldiv_core_resp_t sel;
  logic [DLEN-1:0]    fixed;

  // wraps for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ------------------------------
  // issue order queue
  // ------------------------------

  assign issue_rdy = (occ_q != OCC_W'(ORDER_DEPTH));
  assign push      = issue_val && issue_rdy;
  assign head      = order_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      occ_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop) begin
        occ_q <= occ_q + 1'b1;
      end else if (pop && !push) begin
        occ_q <= occ_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) order_q[wr_ptr_q] <= issue_unit;
  end

  // ------------------------------
  // take from the head core
  // ------------------------------

  // output register empty or draining, and something is outstanding
  assign take_rdy     = (occ_q != '0) && (!resp_val || resp_rdy);
  assign mul_resp_rdy = take_rdy && (head == UNIT_MUL);
  assign div_resp_rdy = take_rdy && (head == UNIT_DIV);
  assign pop = (mul_resp_val && mul_resp_rdy) || (div_resp_val && div_resp_rdy);
  assign sel = (head == UNIT_MUL) ? mul_resp_msg : div_resp_msg;

  // multiply negates the full product, divide negates each half on its own
  always_comb begin
    if (sel.is_mul) begin
      fixed = sel.neg_lo ? (~sel.raw + 1'b1) : sel.raw;
    end else begin
      fixed[DLEN-1:XLEN] = sel.neg_hi ? (~sel.raw[DLEN-1:XLEN] + 1'b1)
                                      : sel.raw[DLEN-1:XLEN];
      fixed[XLEN-1:0]    = sel.neg_lo ? (~sel.raw[XLEN-1:0] + 1'b1)
                                      : sel.raw[XLEN-1:0];
    end
  end

  // ------------------------------
  // response register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (pop) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) resp_msg.result <= fixed;
  end

endmodule

//--- source/imuldiv_top.sv
/*
  integer multiply/divide unit, val/rdy on both sides
  responses return in request order
*/
`timescale 1ns/1ns

module imuldiv_top #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  input  imuldiv_pkg::imuldiv_req_t  req_msg,
  output logic                       req_rdy,
  output logic                       resp_val,
  output imuldiv_pkg::imuldiv_resp_t resp_msg,
  input  logic                       resp_rdy
);
  import imuldiv_pkg::*;

  // operand stage to cores
  logic               mul_req_val;
  imuldiv_core_req_t  mul_req_msg;
  logic               mul_req_rdy;
  logic               div_req_val;
  imuldiv_core_req_t  div_req_msg;
  logic               div_req_rdy;

  // issue order tag
  logic               issue_val;
  imuldiv_unit_e      issue_unit;
  logic               issue_rdy;

  // cores to result stage
  logic               mul_resp_val;
  imuldiv_core_resp_t mul_resp_msg;
  logic               mul_resp_rdy;
  logic               div_resp_val;
  imuldiv_core_resp_t div_resp_msg;
  logic               div_resp_rdy;

  imuldiv_operand_stage operand0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_msg     (req_msg),
    .req_rdy     (req_rdy),
    .mul_req_val (mul_req_val),
    .mul_req_msg (mul_req_msg),
    .mul_req_rdy (mul_req_rdy),
    .div_req_val (div_req_val),
    .div_req_msg (div_req_msg),
    .div_req_rdy (div_req_rdy),
    .issue_val   (issue_val),
    .issue_unit  (issue_unit),
    .issue_rdy   (issue_rdy)
  );

  imuldiv_mul_iterative mul0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_msg  (mul_req_msg),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_msg (mul_resp_msg),
    .resp_rdy (mul_resp_rdy)
  );

  imuldiv_div_iterative div0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_msg  (div_req_msg),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_msg (div_resp_msg),
    .resp_rdy (div_resp_rdy)
  );

  imuldiv_result_stage #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) result0 (
    .clk          (clk),
    .reset        (reset),
    .issue_val    (issue_val),
    .issue_unit   (issue_unit),
    .issue_rdy    (issue_rdy),
    .mul_resp_val (mul_resp_val),
    .mul_resp_msg (mul_resp_msg),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_val (div_resp_val),
    .div_resp_msg (div_resp_msg),
    .div_resp_rdy (div_resp_rdy),
    .resp_val     (resp_val),
    .resp_msg     (resp_msg),
    .resp_rdy     (resp_rdy)
  );

endmodule

//--- dv/imuldiv_checks.svh
/*
  expected results and compare tasks for the imuldiv testbench
  included inside the testbench module, uses its check and error counters
*/
`ifndef IMULDIV_CHECKS_SVH
`define IMULDIV_CHECKS_SVH

// expected response from the arithmetic definition of each opcode
function automatic imuldiv_resp_t imuldiv_ref(input imuldiv_req_t req);
  longint        sa;
  longint        sb;
  logic [63:0]   ua;
  logic [63:0]   ub;
  logic [31:0]   q;
  logic [31:0]   r;
  imuldiv_resp_t resp;
  sa = longint'($signed(req.a));
  sb = longint'($signed(req.b));
  ua = {32'b0, req.a};
  ub = {32'b0, req.b};
  q  = '0;
  r  = '0;
  case (req.op)
    OP_MUL:  resp.result = sa * sb;
    OP_MULU: resp.result = ua * ub;
    OP_DIV: begin
      if (req.b == '0) begin
        // all ones quotient magnitude, negated when the dividend is negative
        q = req.a[31] ? 32'h0000_0001 : 32'hffff_ffff;
        r = req.a;
      end else begin
        // 64-bit math so the most negative / -1 case does not overflow
        q = 32'(sa / sb);
        r = 32'(sa % sb);
      end
      resp.result = {r, q};
    end
    default: begin
      q = (req.b == '0) ? 32'hffff_ffff : req.a / req.b;
      r = (req.b == '0) ? req.a : req.a % req.b;
      resp.result = {r, q};
    end
  endcase
  return resp;
endfunction

task automatic check_resp(input string name, input imuldiv_resp_t exp, input imuldiv_resp_t act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("CHECK FAILED %s expected %h actual %h", name, exp.result, act.result);
  end
endtask

task automatic check_count(input string name, input int exp, input int act);
  checks++;
  if (act != exp) begin
    errors++;
    $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
  end
endtask

`endif

//--- dv/imuldiv_tb.sv
/*
  drives imuldiv_top with directed and random requests, responses checked in order
  latency check assumes an empty pipeline and resp_rdy held high
*/
`timescale 1ns/1ns

module imuldiv_tb;
  import imuldiv_pkg::*;

  // ------------------------------
  // test sizes and limits
  // ------------------------------
  localparam int N_MUL_DIR = 16;
  localparam int N_MUL_RND = 16;
  localparam int N_DIV_DIR = 10;
  localparam int N_DIV_RND = 16;
  localparam int N_DBZ     = 8;
  localparam int N_OVL     = 16;
  localparam int N_BP      = 24;
  localparam int N_LAT     = 4;
  localparam int N_REQ = N_MUL_DIR + N_MUL_RND + N_DIV_DIR + N_DIV_RND + N_DBZ + N_OVL
                         + N_BP + N_LAT;
  localparam int TIMEOUT = N_REQ * 40 + 200;
  // operand register, dispatch into the core, 32 calc steps, result register
  localparam int LATENCY = 35;
  // overlapped cores finish in about half the serial time
  localparam int OVL_BOUND = (N_OVL / 2 + 2) * 35;

  logic          clk;
  logic          reset;
  logic          req_val;
  imuldiv_req_t  req_msg;
  logic          req_rdy;
  logic          resp_val;
  imuldiv_resp_t resp_msg;
  logic          resp_rdy;

  int            cycle = 0;
  int            checks = 0;
  int            errors = 0;
  int            resp_count = 0;
  imuldiv_req_t  req_q[$];
  string         name_q[$];
  logic          bp_on = 1'b0;
  logic          saw_stall = 1'b0;
  int            bp_left = 0;
  logic          bp_lvl = 1'b1;

  logic [31:0] mul_a [8] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                             32'hffff_ffff, 32'h0, 32'h7fff_ffff, 32'h8000_0000};
  logic [31:0] mul_b [8] = '{32'h0, 32'h1234_5678, 32'hffff_ffff, 32'h8000_0000,
                             32'h1, 32'hffff_ffff, 32'h7fff_ffff, 32'hffff_ffff};
  // every sign combination, then most negative by -1
  logic [31:0] div_a [5] = '{32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c, 32'h8000_0000};
  logic [31:0] div_b [5] = '{32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9, 32'hffff_ffff};
  logic [31:0] dbz_a [4] = '{32'd12345, 32'hffff_cfc7, 32'h0, 32'h8000_0000};

  `include "imuldiv_checks.svh"

  imuldiv_top #(.ORDER_DEPTH(2)) dut0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_msg  (req_msg),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_msg (resp_msg),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------
  // helpers
  // ------------------------------

  // random signedness within one core
  function automatic imuldiv_op_e rand_op(input logic to_mul);
    if (to_mul) return ($urandom_range(1, 0) != 0) ? OP_MUL : OP_MULU;
    return ($urandom_range(1, 0) != 0) ? OP_DIV : OP_DIVU;
  endfunction

  // call 5 ns after a rising edge, returns at the same point after the transfer edge
  task automatic send(input string name, input imuldiv_op_e op, input logic [31:0] a,
                      input logic [31:0] b, output int acc_edge);
    req_val = 1'b1;
    req_msg = '{op: op, a: a, b: b};
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    acc_edge = cycle + 1;
    req_q.push_back(req_msg);
    name_q.push_back(name);
    @(posedge clk);
    #5;
    req_val = 1'b0;
  endtask

  // wait until every sent request has its response
  task automatic drain();
    do @(posedge clk); while (req_q.size() != 0);
    #5;
  endtask

  // ------------------------------
  // response side
  // ------------------------------

  // resp_rdy random stretches while back-pressure is on
  initial begin
    resp_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #5;
      if (!bp_on) begin
        resp_rdy = 1'b1;
      end else begin
        if (bp_left == 0) begin
          bp_lvl  = $urandom_range(1, 0);
          bp_left = $urandom_range(6, 1);
        end
        resp_rdy = bp_lvl;
        bp_left--;
      end
    end
  end

  // transfer happens on the next edge, values are stable here
  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (req_q.size() == 0) begin
        errors++;
        $display("response at cycle %0d with no request outstanding", cycle);
      end else begin
        check_resp(name_q.pop_front(), imuldiv_ref(req_q.pop_front()), resp_msg);
        resp_count++;
      end
    end
    // request side blocked while the response is stalled
    if (bp_on && resp_val && !resp_rdy && !req_rdy) saw_stall <= 1'b1;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle == TIMEOUT) begin
      $display("timeout after %0d cycles, %0d requests without response", cycle, name_q.size());
      foreach (name_q[i]) $display("  no response for %s", name_q[i]);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    int acc_edge;
    int start;
    void'($urandom(7105));
    reset   = 1'b1;
    req_val = 1'b0;
    req_msg = '0;
    repeat (8) @(posedge clk);
    #5;
    reset = 1'b0;
    @(negedge clk);
    check_bit("reset_req_rdy", 1'b1, req_rdy);
    check_bit("reset_resp_val", 1'b0, resp_val);
    @(posedge clk);
    #5;

    // multiply corners for both signedness cases, then random
    for (int i = 0; i < N_MUL_DIR; i++) begin
      send($sformatf("mul_dir%0d", i), (i < 8) ? OP_MUL : OP_MULU, mul_a[i % 8], mul_b[i % 8],
           acc_edge);
    end
    for (int i = 0; i < N_MUL_RND; i++) begin
      send($sformatf("mul_rnd%0d", i), rand_op(1'b1), $urandom, $urandom, acc_edge);
    end

    // divide sign combinations, then random
    for (int i = 0; i < N_DIV_DIR; i++) begin
      send($sformatf("div_dir%0d", i), (i < 5) ? OP_DIV : OP_DIVU, div_a[i % 5], div_b[i % 5],
           acc_edge);
    end
    for (int i = 0; i < N_DIV_RND; i++) begin
      send($sformatf("div_rnd%0d", i), rand_op(1'b0), $urandom, $urandom, acc_edge);
    end
    for (int i = 0; i < N_DBZ; i++) begin
      send($sformatf("div_zero%0d", i), (i < 4) ? OP_DIV : OP_DIVU, dbz_a[i % 4], 32'h0,
           acc_edge);
    end
    drain();

    // alternate cores back to back, both should be busy at once
    start = cycle;
    for (int i = 0; i < N_OVL; i++) begin
      send($sformatf("overlap%0d", i), rand_op(i % 2 == 0), $urandom, $urandom, acc_edge);
    end
    drain();
    check_bit("overlap_time", 1'b1, (cycle - start) <= OVL_BOUND);

    // random ops under random response stalls
    bp_on = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      send($sformatf("backpress%0d", i), rand_op($urandom_range(1, 0)), $urandom, $urandom,
           acc_edge);
    end
    drain();
    bp_on = 1'b0;
    check_bit("req_rdy_fell", 1'b1, saw_stall);
    @(posedge clk);
    #5;

    // one request at a time, one per opcode
    for (int i = 0; i < N_LAT; i++) begin
      send($sformatf("latency%0d", i), imuldiv_op_e'(i), $urandom, $urandom, acc_edge);
      @(negedge clk);
      while (!resp_val) @(negedge clk);
      // resp_val is first sampled high on the edge after this one
      check_count($sformatf("latency%0d_cycles", i), LATENCY, cycle + 1 - acc_edge);
      drain();
    end

    check_count("response_count", N_REQ, resp_count);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- imuldiv.f
+incdir+dv
source/imuldiv_pkg.sv
source/imuldiv_operand_stage.sv
source/imuldiv_mul_iterative.sv
source/imuldiv_div_iterative.sv
source/imuldiv_result_stage.sv
source/imuldiv_top.sv
dv/imuldiv_tb.sv

//--- Bender.yml
package:
  name: imuldiv

sources:
  - source/imuldiv_pkg.sv
  - source/imuldiv_operand_stage.sv
  - source/imuldiv_mul_iterative.sv
  - source/imuldiv_div_iterative.sv
  - source/imuldiv_result_stage.sv
  - source/imuldiv_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/imuldiv_tb.sv
